/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module reverb_tb -Mdir obj_dir

run: compile
	./obj_dir/Vreverb_tb > sim.log 2>&1; cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/audio_config.svh */
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// sample word
`define AUDIO_WIDTH 16

// mic slot is wider than what we keep, the low bits are dropped
`define MIC_WORD_BITS 24

// i2s timing, one frame = BCLK_DIV * FRAME_BITS audio_clk cycles
`define BCLK_DIV 32
`define FRAME_BITS 64

// dc blocker pole, y_prev >>> DC_SHIFT
`define DC_SHIFT 8

// impulse response
`define IR_TAPS 8
`define IR_SHIFT 15   // q15 taps

// echo memory
`define DELAY_DEPTH 256

`endif

/* design/audio_output_stage.sv */
`timescale 1ns/1ps
`include "audio_config.svh"

module audio_output_stage (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  audio_pkg::audio_sample_t raw,
  input  audio_pkg::audio_sample_t filtered,
  input  audio_pkg::audio_sample_t convolved,
  input  audio_pkg::audio_sample_t delayed,
  input  audio_pkg::source_sel_e   source,
  output audio_pkg::audio_sample_t sample_out,
  output logic                     pdm_out
);

  audio_pkg::audio_sample_t       selected;
  logic                           out_valid;
  logic signed [`AUDIO_WIDTH-1:0] level;       // held between strobes
  logic [`AUDIO_WIDTH-1:0]        level_off;   // level + 32768
  logic [`AUDIO_WIDTH:0]          pdm_acc;

  always_comb begin
    case (source)
      audio_pkg::SRC_RAW:       selected = raw;
      audio_pkg::SRC_FILTERED:  selected = filtered;
      audio_pkg::SRC_CONVOLVED: selected = convolved;
      audio_pkg::SRC_DELAYED:   selected = delayed;
      default:                  selected = raw;
    endcase
  end

  // flipping the sign bit adds half scale
  assign level_off = {~level[`AUDIO_WIDTH-1], level[`AUDIO_WIDTH-2:0]};

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      level     <= '0;
      pdm_acc   <= '0;
    end else begin
      out_valid <= selected.valid;
      if (selected.valid) level <= selected.data;
      // first order sigma-delta, carry out is the pdm bit
      pdm_acc <= {1'b0, pdm_acc[`AUDIO_WIDTH-1:0]} + {1'b0, level_off};
    end
  end

  assign pdm_out = pdm_acc[`AUDIO_WIDTH];

  assign sample_out.valid = out_valid;
  assign sample_out.data = level;

endmodule

/* design/audio_pkg.sv */
package audio_pkg;

  `include "audio_config.svh"

  // width fed to the saturator, wide enough for every intermediate sum
  localparam int SAT_W = 40;

  typedef struct packed {
    logic                           valid;  // one-cycle strobe
    logic signed [`AUDIO_WIDTH-1:0] data;
  } audio_sample_t;

  typedef enum logic [1:0] {
    SRC_RAW,
    SRC_FILTERED,
    SRC_CONVOLVED,
    SRC_DELAYED
  } source_sel_e;

  typedef struct packed {
    logic        record_impulse;  // pulse
    source_sel_e source;
    logic [7:0]  delay_samples;
  } reverb_ctrl_t;

  // clamp a wide signed value to the sample range
  function automatic logic signed [`AUDIO_WIDTH-1:0] saturate(
    input logic signed [SAT_W-1:0] value
  );
    logic [SAT_W-`AUDIO_WIDTH:0] upper;
    upper = value[SAT_W-1:`AUDIO_WIDTH-1];
    if (&upper || ~|upper) return value[`AUDIO_WIDTH-1:0];  // in range
    if (value[SAT_W-1]) return {1'b1, {(`AUDIO_WIDTH-1){1'b0}}};
    return {1'b0, {(`AUDIO_WIDTH-1){1'b1}}};
  endfunction

endpackage

/* design/dc_blocker.sv */
`timescale 1ns/1ps
`include "audio_config.svh"

module dc_blocker (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  audio_pkg::audio_sample_t sample_in,
  output audio_pkg::audio_sample_t sample_out
);

  // three guard bits cover x - x_prev + y_prev - y_prev/256
  localparam int SUM_W = `AUDIO_WIDTH + 3;

  logic signed [`AUDIO_WIDTH-1:0] x_prev;
  logic signed [`AUDIO_WIDTH-1:0] y_prev;
  logic signed [SUM_W-1:0]        y_next;
  logic signed [audio_pkg::SAT_W-1:0] y_wide;
  logic                           out_valid;

  // y[n] = x[n] - x[n-1] + y[n-1] - (y[n-1] >>> 8)
  assign y_next = SUM_W'(sample_in.data) - SUM_W'(x_prev)
                + SUM_W'(y_prev) - SUM_W'(y_prev >>> `DC_SHIFT);
  assign y_wide = audio_pkg::SAT_W'(y_next);

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      x_prev    <= '0;
      y_prev    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= sample_in.valid;
      if (sample_in.valid) begin
        x_prev <= sample_in.data;
        y_prev <= audio_pkg::saturate(y_wide);
      end
    end
  end

  assign sample_out.valid = out_valid;
  assign sample_out.data = y_prev;  // last output doubles as the held result

endmodule

/* design/echo_delay.sv */
`timescale 1ns/1ps
`include "audio_config.svh"

module echo_delay (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  audio_pkg::audio_sample_t sample_in,
  input  logic [7:0]               delay_samples,
  output audio_pkg::audio_sample_t sample_out
);

  localparam int ADDR_W = $clog2(`DELAY_DEPTH);

  logic signed [`AUDIO_WIDTH-1:0] mem [`DELAY_DEPTH];
  logic [`DELAY_DEPTH-1:0]        written;  // entry holds real audio
  logic [ADDR_W-1:0]              wr_ptr;
  logic [ADDR_W-1:0]              rd_ptr;
  logic signed [`AUDIO_WIDTH-1:0] rd_data;
  logic                           out_valid;
  logic signed [`AUDIO_WIDTH-1:0] out_data;

  // current write slot is delay 0, one behind is delay 1
  assign rd_ptr = wr_ptr - ADDR_W'(delay_samples);
  assign rd_data = written[rd_ptr] ? mem[rd_ptr] : '0;

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      written   <= '0;
      wr_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= sample_in.valid;
      if (sample_in.valid) begin
        written[wr_ptr] <= 1'b1;
        wr_ptr          <= wr_ptr + 1'b1;  // circular
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (sample_in.valid) begin
      mem[wr_ptr] <= sample_in.data;
      // bypass since the slot is only being written now
      out_data <= (delay_samples == 8'd0) ? sample_in.data : rd_data;
    end
  end

  assign sample_out.valid = out_valid;
  assign sample_out.data = out_data;

endmodule

/* design/i2s_receiver.sv */
`timescale 1ns/1ps
`include "audio_config.svh"

module i2s_receiver (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  logic                     mic_data,
  output logic                     i2s_clk,
  output logic                     lrcl_clk,
  output audio_pkg::audio_sample_t raw
);

  localparam int BIT_W = $clog2(`BCLK_DIV);     // cycles within one bit clock
  localparam int SLOT_W = $clog2(`FRAME_BITS);  // bit clock index within the frame
  localparam int CNT_W = BIT_W + SLOT_W;
  localparam int HALF_DIV = `BCLK_DIV / 2;

  logic [CNT_W-1:0]               frame_cnt;
  logic [SLOT_W-1:0]              bit_idx;
  logic                           rise_next;
  logic                           left_slot;
  logic                           keep_bit;
  logic                           word_done;
  logic signed [`AUDIO_WIDTH-1:0] shift_q;

  // clocks come straight off counter bits, no glitches
  assign i2s_clk = frame_cnt[BIT_W-1];
  assign lrcl_clk = frame_cnt[CNT_W-1];  // flips with the falling edge at slot 32

  assign bit_idx = frame_cnt[CNT_W-1:BIT_W];
  assign left_slot = bit_idx < SLOT_W'(`FRAME_BITS / 2);

  // the edge that ends this cycle raises i2s_clk
  assign rise_next = frame_cnt[BIT_W-1:0] == BIT_W'(HALF_DIV - 1);

  // data bit k sits on rising edge k+1, keep the top AUDIO_WIDTH bits
  assign keep_bit = rise_next && left_slot
                    && bit_idx >= SLOT_W'(1)
                    && bit_idx <= SLOT_W'(`AUDIO_WIDTH);

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      frame_cnt <= '0;
      word_done <= 1'b0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;  // wraps once per frame
      word_done <= keep_bit && (bit_idx == SLOT_W'(`AUDIO_WIDTH));
    end
  end

  // msb first
  always_ff @(posedge audio_clk) begin
    if (keep_bit) begin
      shift_q <= {shift_q[`AUDIO_WIDTH-2:0], mic_data};
    end
  end

  // shift_q is untouched until the next frame, so it is stable with the strobe
  assign raw.valid = word_done;
  assign raw.data = shift_q;

endmodule

/* design/impulse_convolver.sv */
`timescale 1ns/1ps
`include "audio_config.svh"

module impulse_convolver (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  audio_pkg::audio_sample_t sample_in,
  input  logic                     record_impulse,
  output logic                     ir_ready,
  output audio_pkg::audio_sample_t sample_out
);

  localparam int TAP_W = $clog2(`IR_TAPS);
  localparam int PROD_W = 2 * `AUDIO_WIDTH;
  localparam int ACC_W = PROD_W + TAP_W;  // room for IR_TAPS full-scale products

  typedef enum logic [1:0] {
    CONV_IDLE,
    CONV_MAC,
    CONV_OUT
  } conv_state_e;

  conv_state_e state;

  logic signed [`AUDIO_WIDTH-1:0] taps [`IR_TAPS];
  logic signed [`AUDIO_WIDTH-1:0] hist [`IR_TAPS];  // hist[k] is the input k samples ago

  logic                           recording;
  logic [TAP_W-1:0]               rec_idx;
  logic [TAP_W-1:0]               mac_idx;
  logic signed [PROD_W-1:0]       product;
  logic signed [ACC_W-1:0]        acc;
  logic signed [audio_pkg::SAT_W-1:0] acc_scaled;
  logic                           out_valid;
  logic signed [`AUDIO_WIDTH-1:0] out_data;
  logic                           take_tap;

  assign product = PROD_W'(taps[mac_idx]) * PROD_W'(hist[mac_idx]);
  assign acc_scaled = audio_pkg::SAT_W'(acc >>> `IR_SHIFT);

  // a fresh record pulse wins over a sample in the same cycle
  assign take_tap = sample_in.valid && recording && !record_impulse;

  // recording control and the mac sequencer
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      ir_ready  <= 1'b0;
      recording <= 1'b0;
      rec_idx   <= '0;
      mac_idx   <= '0;
      state     <= CONV_IDLE;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;

      if (record_impulse) begin
        recording <= 1'b1;
        rec_idx   <= '0;
        ir_ready  <= 1'b0;
      end else if (take_tap) begin
        rec_idx <= rec_idx + 1'b1;
        if (rec_idx == TAP_W'(`IR_TAPS - 1)) begin
          recording <= 1'b0;
          ir_ready  <= 1'b1;  // all taps captured
        end
      end

      case (state)
        CONV_IDLE: begin
          if (sample_in.valid) begin
            mac_idx <= '0;
            state   <= CONV_MAC;
          end
        end
        CONV_MAC: begin
          mac_idx <= mac_idx + 1'b1;  // one product per cycle
          if (mac_idx == TAP_W'(`IR_TAPS - 1)) state <= CONV_OUT;
        end
        CONV_OUT: begin
          out_valid <= 1'b1;
          state     <= CONV_IDLE;
        end
        default: state <= CONV_IDLE;
      endcase
    end
  end

  // tap memory, history line and accumulator
  always_ff @(posedge audio_clk) begin
    if (sample_in.valid) begin
      for (int i = `IR_TAPS - 1; i > 0; i--) begin
        hist[i] <= hist[i-1];
      end
      hist[0] <= sample_in.data;
    end

    if (take_tap) taps[rec_idx] <= sample_in.data;

    case (state)
      CONV_IDLE: if (sample_in.valid) acc <= '0;
      CONV_MAC:  acc <= acc + ACC_W'(product);
      CONV_OUT: begin
        // silent until a full impulse response is in place
        out_data <= ir_ready ? audio_pkg::saturate(acc_scaled) : '0;
      end
      default: acc <= '0;
    endcase
  end

  assign sample_out.valid = out_valid;
  assign sample_out.data = out_data;

endmodule

/* design/reverb_top.sv */
`timescale 1ns/1ps

module reverb_top (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  logic                     mic_data,
  output logic                     i2s_clk,
  output logic                     lrcl_clk,
  input  audio_pkg::reverb_ctrl_t  ctrl,
  output logic                     ir_ready,
  output audio_pkg::audio_sample_t sample_out,
  output logic                     pdm_out
);

  audio_pkg::audio_sample_t raw_sample;
  audio_pkg::audio_sample_t filtered_sample;
  audio_pkg::audio_sample_t convolved_sample;
  audio_pkg::audio_sample_t delayed_sample;

  i2s_receiver mic_rx (
    .audio_clk (audio_clk),
    .reset     (reset),
    .mic_data  (mic_data),
    .i2s_clk   (i2s_clk),
    .lrcl_clk  (lrcl_clk),
    .raw       (raw_sample)
  );

  dc_blocker dc_block (
    .audio_clk  (audio_clk),
    .reset      (reset),
    .sample_in  (raw_sample),
    .sample_out (filtered_sample)
  );

  // convolver and echo both run off the dc-blocked stream
  impulse_convolver conv (
    .audio_clk      (audio_clk),
    .reset          (reset),
    .sample_in      (filtered_sample),
    .record_impulse (ctrl.record_impulse),
    .ir_ready       (ir_ready),
    .sample_out     (convolved_sample)
  );

  echo_delay echo (
    .audio_clk     (audio_clk),
    .reset         (reset),
    .sample_in     (filtered_sample),
    .delay_samples (ctrl.delay_samples),
    .sample_out    (delayed_sample)
  );

  audio_output_stage out_stage (
    .audio_clk  (audio_clk),
    .reset      (reset),
    .raw        (raw_sample),
    .filtered   (filtered_sample),
    .convolved  (convolved_sample),
    .delayed    (delayed_sample),
    .source     (ctrl.source),
    .sample_out (sample_out),
    .pdm_out    (pdm_out)
  );

endmodule

/* tb.f */
+incdir+design
design/audio_pkg.sv
design/i2s_receiver.sv
design/dc_blocker.sv
design/impulse_convolver.sv
design/echo_delay.sv
design/audio_output_stage.sv
design/reverb_top.sv
test/reverb_assertions.sv
test/reverb_tb.sv

/* test/reverb_assertions.sv */
`timescale 1ns/1ps

module reverb_assertions (
  input logic                     audio_clk,
  input logic                     reset,
  input logic                     i2s_clk,
  input logic                     lrcl_clk,
  input audio_pkg::audio_sample_t sample_out,
  input logic                     pdm_out
);

  int fail_count = 0;  // failures so far, summed into the final verdict

  // word clock moves only on a falling bit clock
  lrcl_on_bclk_fall: assert property (@(posedge audio_clk) disable iff (reset)
    $changed(lrcl_clk) |-> $fell(i2s_clk))
    else begin
      $error("lrcl_clk changed away from a falling i2s_clk");
      fail_count++;
    end

  valid_single_cycle: assert property (@(posedge audio_clk) disable iff (reset)
    sample_out.valid |=> !sample_out.valid)
    else begin
      $error("sample_out.valid held for two cycles");
      fail_count++;
    end

  pdm_known: assert property (@(posedge audio_clk) disable iff (reset)
    !$isunknown(pdm_out))
    else begin
      $error("pdm_out is unknown");
      fail_count++;
    end

endmodule

bind reverb_top reverb_assertions chk_i (
  .audio_clk  (audio_clk),
  .reset      (reset),
  .i2s_clk    (i2s_clk),
  .lrcl_clk   (lrcl_clk),
  .sample_out (sample_out),
  .pdm_out    (pdm_out)
);

/* test/reverb_tb.sv */
`timescale 1ns/1ps
`include "audio_config.svh"

module reverb_tb;

  localparam int FRAME = `BCLK_DIV * `FRAME_BITS;
  // frames per test: reset, decode, dc, convolution, echo, pdm
  localparam int TOTAL_FRAMES = 2 + 10 + 26 + 30 + 24 + 6;
  localparam int CYCLE_LIMIT = FRAME * TOTAL_FRAMES * 2;

  logic                     audio_clk;
  logic                     reset;
  logic                     mic_data;
  logic                     i2s_clk;
  logic                     lrcl_clk;
  audio_pkg::reverb_ctrl_t  ctrl;
  logic                     ir_ready;
  audio_pkg::audio_sample_t sample_out;
  logic                     pdm_out;

  int errors = 0;
  int tests_failed = 0;
  int tests_run = 0;
  int cycles = 0;
  int strobe_cnt = 0;
  int fall_cnt;
  logic i2s_prev;
  logic [23:0] cur_word;
  logic [23:0] mic_q[$];
  audio_pkg::audio_sample_t last_got;
  audio_pkg::audio_sample_t last_exp;

  // reference model state
  int xp;
  int yp;
  logic signed [15:0] taps_m[`IR_TAPS];
  logic signed [15:0] hist_m[`IR_TAPS];
  bit rec_on;
  bit ready_m;
  int rec_n;
  logic signed [15:0] echo_m[`DELAY_DEPTH];
  int echo_n;
  logic signed [15:0] q_raw[$];
  logic signed [15:0] q_filt[$];
  logic signed [15:0] q_conv[$];
  logic signed [15:0] q_del[$];

  reverb_top dut_i (.*);

  initial audio_clk = 1'b0;
  always #5 audio_clk = ~audio_clk;

  always @(posedge audio_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic signed [15:0] clamp16(input longint v);
    if (v > 32767) return 16'sd32767;
    if (v < -32768) return -16'sd32768;
    return v[15:0];
  endfunction

  // one frame through the dc, convolver and echo models
  task automatic model_frame(input logic [23:0] w);
    int x;
    int y;
    int n;
    longint acc;
    x = $signed(w[23:8]);
    y = clamp16(x - xp + yp - (yp >>> `DC_SHIFT));
    xp = x;
    yp = y;
    for (int k = `IR_TAPS - 1; k > 0; k--) hist_m[k] = hist_m[k-1];
    hist_m[0] = y;
    if (rec_on) begin
      taps_m[rec_n] = y;
      rec_n++;
      if (rec_n == `IR_TAPS) begin
        rec_on = 0;
        ready_m = 1;
      end
    end
    acc = 0;
    for (int k = 0; k < `IR_TAPS; k++) acc += longint'(taps_m[k]) * longint'(hist_m[k]);
    q_conv.push_back(ready_m ? clamp16(acc >>> `IR_SHIFT) : 16'sd0);
    n = ctrl.delay_samples;
    if (n == 0) q_del.push_back(y);
    else q_del.push_back(echo_n >= n ? echo_m[(echo_n - n) % `DELAY_DEPTH] : 16'sd0);
    echo_m[echo_n % `DELAY_DEPTH] = y;
    echo_n++;
    q_raw.push_back(x);
    q_filt.push_back(y);
  endtask

  // microphone, data bit k goes out after falling edge k+1
  always @(negedge audio_clk) begin
    if (reset) begin
      fall_cnt = 0;
      i2s_prev = 0;
      mic_data = 0;
      xp = 0;
      yp = 0;
      rec_on = 0;
      ready_m = 0;
      echo_n = 0;
      q_raw.delete();
      q_filt.delete();
      q_conv.delete();
      q_del.delete();
    end else begin
      if (i2s_prev && !i2s_clk) begin
        fall_cnt++;
        if (fall_cnt % 64 == 1) begin
          cur_word = mic_q.size() > 0 ? mic_q.pop_front() : 24'h0;
          model_frame(cur_word);
        end
        if (fall_cnt % 64 >= 1 && fall_cnt % 64 <= `MIC_WORD_BITS)
          mic_data = cur_word[`MIC_WORD_BITS - fall_cnt % 64];
        else
          mic_data = 0;
      end
      i2s_prev = i2s_clk;
    end
  end

  // output monitor pairs each strobe with the model sample of that frame
  always @(negedge audio_clk) begin
    if (!reset && sample_out.valid) begin
      if (q_raw.size() == 0) begin
        $display("** Error at %0t: output strobe without a sent sample", $time);
        errors++;
      end else begin
        last_exp.valid = 1'b1;
        last_exp.data = q_raw.pop_front();
        if (ctrl.source == audio_pkg::SRC_FILTERED) last_exp.data = q_filt[0];
        if (ctrl.source == audio_pkg::SRC_CONVOLVED) last_exp.data = q_conv[0];
        if (ctrl.source == audio_pkg::SRC_DELAYED) last_exp.data = q_del[0];
        void'(q_filt.pop_front());
        void'(q_conv.pop_front());
        void'(q_del.pop_front());
      end
      last_got = sample_out;
      strobe_cnt++;
    end
  end

  task automatic compare_sample(input string what, input audio_pkg::audio_sample_t got,
                                input audio_pkg::audio_sample_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %0b/%0d expected %0b/%0d", $time, what,
               got.valid, got.data, exp.valid, exp.data);
      errors++;
    end
  endtask

  task automatic compare_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_level(input int exp, input int got);
    if (got < exp - 1 || got > exp + 1) begin
      $display("** Error at %0t: pdm ones %0d, expected %0d +-1", $time, got, exp);
      errors++;
    end
  endtask

  task automatic wait_strobe(output audio_pkg::audio_sample_t got,
                             output audio_pkg::audio_sample_t exp);
    int start;
    start = strobe_cnt;
    wait (strobe_cnt != start);
    got = last_got;
    exp = last_exp;
  endtask

  // change controls in the right slot, after all strobes of the frame
  task automatic set_ctrl(input audio_pkg::source_sel_e src, input logic [7:0] n);
    @(posedge lrcl_clk);
    @(negedge audio_clk);
    ctrl.source = src;
    ctrl.delay_samples = n;
  endtask

  // one-cycle record pulse in the right slot, the model starts a fresh capture with it
  task automatic pulse_record();
    @(posedge lrcl_clk);
    @(negedge audio_clk);
    ctrl.record_impulse = 1'b1;
    rec_on = 1;
    rec_n = 0;
    ready_m = 0;
    @(negedge audio_clk);
    ctrl.record_impulse = 1'b0;
  endtask

  task automatic check_frames(input string what, input int frames);
    audio_pkg::audio_sample_t got;
    audio_pkg::audio_sample_t exp;
    repeat (frames) begin
      wait_strobe(got, exp);
      compare_sample(what, got, exp);
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) $display("test %s: ok", name);
    else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic test_reset();
    int e;
    e = errors;
    repeat (2) begin
      @(negedge audio_clk);
      compare_flag("i2s_clk", i2s_clk, 0);
      compare_flag("lrcl_clk", lrcl_clk, 0);
      compare_flag("pdm_out", pdm_out, 0);
      compare_flag("ir_ready", ir_ready, 0);
      compare_flag("sample_out.valid", sample_out.valid, 0);
    end
    reset = 0;
    @(negedge audio_clk);
    compare_flag("i2s_clk after reset", i2s_clk, 0);
    compare_flag("lrcl_clk after reset", lrcl_clk, 0);
    compare_flag("pdm_out after reset", pdm_out, 0);
    compare_flag("ir_ready after reset", ir_ready, 0);
    compare_flag("valid after reset", sample_out.valid, 0);
    report("reset", e);
  endtask

  task automatic test_decode();
    int e;
    logic [23:0] words[$];
    audio_pkg::audio_sample_t got;
    audio_pkg::audio_sample_t exp;
    e = errors;
    set_ctrl(audio_pkg::SRC_RAW, 0);
    repeat (8) words.push_back(24'($urandom));
    foreach (words[i]) mic_q.push_back(words[i]);
    foreach (words[i]) begin
      wait_strobe(got, exp);
      compare_sample("decode", got, {1'b1, words[i][23:8]});
    end
    report("decode", e);
  endtask

  task automatic test_dc();
    int e;
    int first;
    audio_pkg::audio_sample_t got;
    audio_pkg::audio_sample_t exp;
    e = errors;
    set_ctrl(audio_pkg::SRC_FILTERED, 0);
    repeat (24) mic_q.push_back(24'h300000);
    wait_strobe(got, exp);
    compare_sample("dc step", got, exp);
    first = got.data < 0 ? -got.data : got.data;
    repeat (23) begin
      wait_strobe(got, exp);
      compare_sample("dc decay", got, exp);
    end
    if ((got.data < 0 ? -got.data : got.data) >= first) begin
      $display("dc output did not decay toward zero");
      errors++;
    end
    report("dc_removal", e);
  endtask

  task automatic test_conv();
    int e;
    e = errors;
    set_ctrl(audio_pkg::SRC_CONVOLVED, 0);
    pulse_record();
    for (int k = 0; k < `IR_TAPS; k++) mic_q.push_back(24'h400000 >> k);
    check_frames("convolve record", `IR_TAPS);
    compare_flag("ir_ready after taps", ir_ready, 1);
    repeat (12) mic_q.push_back(24'($urandom));
    check_frames("convolve", 12);
    // a new capture drops the old response and silences the output
    pulse_record();
    compare_flag("ir_ready after record", ir_ready, 0);
    check_frames("convolve silent", 2);
    report("convolution", e);
  endtask

  task automatic test_echo();
    int e;
    e = errors;
    set_ctrl(audio_pkg::SRC_DELAYED, 8'd3);
    repeat (10) mic_q.push_back(24'($urandom));
    check_frames("echo 3", 10);
    set_ctrl(audio_pkg::SRC_DELAYED, 8'd0);
    repeat (4) mic_q.push_back(24'($urandom));
    check_frames("echo 0", 4);
    set_ctrl(audio_pkg::SRC_DELAYED, 8'd200);  // older than the run
    check_frames("echo 200", 3);
    report("echo", e);
  endtask

  task automatic test_pdm();
    int e;
    int ones;
    int lvl;
    audio_pkg::audio_sample_t got;
    audio_pkg::audio_sample_t exp;
    e = errors;
    lvl = 16384;
    set_ctrl(audio_pkg::SRC_RAW, 0);
    repeat (4) mic_q.push_back({16'(lvl), 8'h00});
    repeat (2) wait_strobe(got, exp);
    ones = 0;
    repeat (FRAME) begin
      @(negedge audio_clk);
      ones += pdm_out;
    end
    compare_level((lvl + 32768) * FRAME / 65536, ones);
    report("pdm_density", e);
  endtask

  initial begin
    reset = 1'b1;
    mic_data = 1'b0;
    ctrl = '0;
    void'($urandom(32'h745b0d44));
    test_reset();
    test_decode();
    test_dc();
    test_conv();
    test_echo();
    test_pdm();
    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d", tests_run,
             tests_failed, errors, dut_i.chk_i.fail_count);
    if (errors == 0 && dut_i.chk_i.fail_count == 0) $display("Simulation finished: PASS");
    else $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
